/* src/frame_buffer_pkg.sv */
package frame_buffer_pkg;

    typedef logic [3:0]  pixel_t;    // palette index
    typedef logic [7:0]  colour_t;   // one rgb channel
    typedef logic [7:0]  sd_byte_t;  // card data byte
    typedef logic [31:0] sd_addr_t;  // card byte address

    localparam int       sector_size = 512;         // bytes per card sector
    localparam sd_addr_t image_base  = 32'd512;     // first image follows the directory sector

    typedef enum logic [3:0] {
        dir_read_wait,   // wait for card, then read sector 0
        dir_read,
        idle,
        load_wait,       // wait for card, then read one image sector
        load_sector,
        showing,         // image on screen, waiting for next_image
        drawing,
        save_wait,       // wait for card, then write one image sector
        save_sector,
        dir_write_wait,  // rewrite sector 0 after a save
        dir_write
    } store_state_t;

endpackage

/* src/brush_hit.sv */
`timescale 1ns/1ps

module brush_hit #(
    parameter int img_width  = 32,
    parameter int img_height = 32
) (
    input  logic [$clog2(img_width)-1:0]  hcount,
    input  logic [$clog2(img_height)-1:0] vcount,
    input  logic [$clog2(img_width)-1:0]  x_in,
    input  logic [$clog2(img_height)-1:0] y_in,
    input  logic [2:0]                    brush_size,
    output logic                          hit
);
    localparam int xw  = $clog2(img_width);
    localparam int yw  = $clog2(img_height);
    localparam int xqw = 2 * xw + 2;                   // width of dx squared
    localparam int yqw = 2 * yw + 2;
    localparam int sw  = ((xqw > yqw) ? xqw : yqw) + 1;  // room for the sum

    logic signed [xw:0] dx;
    logic signed [yw:0] dy;
    logic [xqw-1:0]     dx_sq;
    logic [yqw-1:0]     dy_sq;
    logic [3:0]         radius;
    logic [7:0]         radius_sq;

    assign radius    = {brush_size, 1'b1};             // (size + 1) * 2 - 1
    assign radius_sq = 8'(radius) * 8'(radius);
    assign dx        = $signed({1'b0, hcount}) - $signed({1'b0, x_in});
    assign dy        = $signed({1'b0, vcount}) - $signed({1'b0, y_in});
    assign dx_sq     = xqw'(dx) * xqw'(dx);            // sign extended before squaring
    assign dy_sq     = yqw'(dy) * yqw'(dy);
    assign hit       = sw'(radius_sq) >= (sw'(dx_sq) + sw'(dy_sq));

endmodule

/* src/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram import frame_buffer_pkg::*; #(
    parameter int depth = 1024
) (
    input  logic                     clk_25mhz,
    input  logic                     reset_SD_card,
    input  logic [$clog2(depth)-1:0] addr_a,
    input  pixel_t                   wdata_a,
    input  logic                     we_a,
    input  logic [$clog2(depth)-1:0] addr_b,
    output pixel_t                   rdata_a,
    output pixel_t                   rdata_b
);
    pixel_t mem [depth];

    // the array powers up black, like a blank bitstream init
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            rdata_a <= '0;
            rdata_b <= '0;
        end else begin
            rdata_a <= mem[addr_a];  // read first, old data on a write
            rdata_b <= mem[addr_b];
        end
    end

endmodule

/* src/palette_lut.sv */
`timescale 1ns/1ps

module palette_lut import frame_buffer_pkg::*; (
    input  pixel_t  index,
    output colour_t red,
    output colour_t green,
    output colour_t blue
);
    always_comb begin
        case (index)
            4'h0:    {red, green, blue} = 24'h000000;  // black
            4'h1:    {red, green, blue} = 24'hFFFFFF;  // white
            4'h2:    {red, green, blue} = 24'hFF0000;  // red
            4'h3:    {red, green, blue} = 24'h00FF00;  // green
            4'h4:    {red, green, blue} = 24'h0000FF;  // blue
            4'h5:    {red, green, blue} = 24'h00FFFF;  // cyan
            4'h6:    {red, green, blue} = 24'hFF00FF;  // magenta
            4'h7:    {red, green, blue} = 24'hFFFF00;  // yellow
            4'h8:    {red, green, blue} = 24'h808080;  // gray
            4'h9:    {red, green, blue} = 24'h6C3082;  // eminence
            4'hA:    {red, green, blue} = 24'hFF0080;  // pink
            4'hB:    {red, green, blue} = 24'hFF8000;  // orange
            4'hC:    {red, green, blue} = 24'h8000FF;  // purple
            4'hD:    {red, green, blue} = 24'h0080FF;  // cool blue
            4'hE:    {red, green, blue} = 24'h00FF80;  // mint green
            default: {red, green, blue} = 24'h80FF00;  // lime green
        endcase
    end

endmodule

/* src/sd_image_store.sv */
`timescale 1ns/1ps

module sd_image_store import frame_buffer_pkg::*; #(
    parameter int img_pixels = 1024
) (
    input  logic                          clk_25mhz,
    input  logic                          reset_SD_card,
    input  logic                          draw,
    input  logic                          slide_show_en,
    input  logic                          next_image,
    input  pixel_t                        buf_rdata,
    input  logic                          sd_ready,
    input  sd_byte_t                      sd_dout,
    input  logic                          sd_byte_available,
    input  logic                          sd_ready_for_next_byte,
    output logic                          drawing,
    output logic                          busy,
    output logic [$clog2(img_pixels)-1:0] buf_addr,
    output pixel_t                        buf_wdata,
    output logic                          buf_we,
    output logic                          sd_rd,
    output logic                          sd_wr,
    output sd_addr_t                      sd_addr,
    output sd_byte_t                      sd_din
);
    localparam int aw        = $clog2(img_pixels);
    localparam int img_bytes = ((img_pixels + sector_size - 1) / sector_size) * sector_size;
    localparam int cw        = $clog2(img_bytes + 1);

    store_state_t  state;
    sd_addr_t      next_wr;   // next free card address, mirrored in sector 0
    sd_addr_t      rd_ptr;    // next image sector to load
    logic [cw-1:0] pos;       // byte position within the current transfer
    logic          prev_draw, prev_show, prev_next, prev_avail, prev_rfnb;
    logic          draw_fall, show_rise, show_fall, next_rise, avail_rise, rfnb_rise;
    logic          last_byte, image_end, in_image, dir_field;

    assign draw_fall  = prev_draw & ~draw;
    assign show_rise  = slide_show_en & ~prev_show;
    assign show_fall  = ~slide_show_en & prev_show;
    assign next_rise  = next_image & ~prev_next;
    assign avail_rise = sd_byte_available & ~prev_avail;
    assign rfnb_rise  = sd_ready_for_next_byte & ~prev_rfnb;

    assign last_byte = (pos[8:0] == 9'(sector_size - 1));
    assign image_end = (pos == cw'(img_bytes - 1));
    assign in_image  = (pos < cw'(img_pixels));  // past this is sector padding
    assign dir_field = (pos < cw'(4));           // address bytes of sector 0

    // the drawing port hides the state of the same name
    assign drawing = (state == frame_buffer_pkg::drawing);
    assign busy    = !(state inside {idle, showing, frame_buffer_pkg::drawing});

    assign buf_addr  = pos[aw-1:0];
    assign buf_wdata = sd_dout[3:0];
    assign buf_we    = (state == load_sector) && avail_rise && in_image;

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            state      <= dir_read_wait;
            next_wr    <= image_base;
            rd_ptr     <= image_base;
            pos        <= '0;
            sd_rd      <= 1'b0;
            sd_wr      <= 1'b0;
            sd_addr    <= '0;
            sd_din     <= '0;
            prev_draw  <= 1'b0;
            prev_show  <= 1'b0;
            prev_next  <= 1'b0;
            prev_avail <= 1'b0;
            prev_rfnb  <= 1'b0;
        end else begin
            prev_draw  <= draw;
            prev_show  <= slide_show_en;
            prev_next  <= next_image;
            prev_avail <= sd_byte_available;
            prev_rfnb  <= sd_ready_for_next_byte;
            sd_rd      <= 1'b0;  // strobes last one cycle
            sd_wr      <= 1'b0;
            case (state)
                dir_read_wait: begin
                    if (sd_ready) begin
                        sd_rd   <= 1'b1;
                        sd_addr <= '0;
                        pos     <= '0;
                        state   <= dir_read;
                    end
                end
                dir_read: begin
                    if (avail_rise) begin
                        if (dir_field) begin
                            next_wr[8*pos[1:0] +: 8] <= sd_dout;  // lsb first
                        end
                        pos <= pos + 1'b1;
                        if (last_byte) begin
                            rd_ptr <= image_base;
                            // a blank card reads zero, keep images clear of sector 0
                            if (next_wr < image_base) begin
                                next_wr <= image_base;
                            end
                            state <= slide_show_en ? showing : idle;
                        end
                    end
                end
                idle: begin
                    if (show_rise) begin
                        state <= dir_read_wait;
                    end else if (draw) begin
                        state <= frame_buffer_pkg::drawing;
                    end
                end
                frame_buffer_pkg::drawing: begin
                    if (draw_fall) begin
                        pos   <= '0;
                        state <= save_wait;
                    end
                end
                save_wait: begin
                    if (sd_ready) begin
                        sd_wr   <= 1'b1;
                        sd_addr <= next_wr;
                        state   <= save_sector;
                    end
                end
                save_sector: begin
                    if (rfnb_rise) begin
                        sd_din <= in_image ? sd_byte_t'(buf_rdata) : '0;
                        pos    <= pos + 1'b1;
                        if (last_byte) begin
                            next_wr <= next_wr + sector_size;
                            state   <= image_end ? dir_write_wait : save_wait;
                        end
                    end
                end
                dir_write_wait: begin
                    if (sd_ready) begin
                        sd_wr   <= 1'b1;
                        sd_addr <= '0;
                        pos     <= '0;
                        state   <= dir_write;
                    end
                end
                dir_write: begin
                    if (rfnb_rise) begin
                        sd_din <= dir_field ? next_wr[8*pos[1:0] +: 8] : '0;
                        pos    <= pos + 1'b1;
                        if (last_byte) begin
                            state <= idle;
                        end
                    end
                end
                showing: begin
                    if (show_fall) begin
                        state <= idle;
                    end else if (next_rise) begin
                        pos   <= '0;
                        state <= (rd_ptr < next_wr) ? load_wait : idle;  // idle once all shown
                    end
                end
                load_wait: begin
                    if (sd_ready) begin
                        sd_rd   <= 1'b1;
                        sd_addr <= rd_ptr;
                        state   <= load_sector;
                    end
                end
                load_sector: begin
                    if (avail_rise) begin
                        pos <= pos + 1'b1;
                        if (last_byte) begin
                            rd_ptr <= rd_ptr + sector_size;
                            state  <= image_end ? showing : load_wait;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* src/frame_buffer_top.sv */
`timescale 1ns/1ps

module frame_buffer_top import frame_buffer_pkg::*; #(
    parameter int img_width  = 32,
    parameter int img_height = 32
) (
    input  logic                          clk_25mhz,
    input  logic                          reset_SD_card,
    input  logic [$clog2(img_width)-1:0]  hcount,
    input  logic [$clog2(img_height)-1:0] vcount,
    input  logic [$clog2(img_width)-1:0]  x_in,
    input  logic [$clog2(img_height)-1:0] y_in,
    input  logic [2:0]                    brush_size,
    input  pixel_t                        color_in,
    input  logic                          draw,
    input  logic                          slide_show_en,
    input  logic                          next_image,
    input  logic                          sd_ready,
    input  sd_byte_t                      sd_dout,
    input  logic                          sd_byte_available,
    input  logic                          sd_ready_for_next_byte,
    output colour_t                       red_out,
    output colour_t                       green_out,
    output colour_t                       blue_out,
    output logic                          sd_rd,
    output logic                          sd_wr,
    output sd_addr_t                      sd_addr,
    output sd_byte_t                      sd_din,
    output logic                          busy
);
    localparam int aw = $clog2(img_width * img_height);

    logic [aw-1:0] raster_addr, addr_a, buf_addr;
    pixel_t        wdata_a, buf_wdata, buf_rdata, pixel;
    logic          we_a, buf_we, hit, drawing;

    assign raster_addr = aw'(hcount) + aw'(img_width) * aw'(vcount);

    // port A belongs to the brush while drawing, to the card store otherwise
    always_comb begin
        if (drawing) begin
            addr_a  = raster_addr;
            wdata_a = color_in;
            we_a    = hit;
        end else begin
            addr_a  = buf_addr;
            wdata_a = buf_wdata;
            we_a    = buf_we;
        end
    end

    brush_hit #(.img_width(img_width), .img_height(img_height)) brush (
        .hcount(hcount), .vcount(vcount), .x_in(x_in), .y_in(y_in),
        .brush_size(brush_size), .hit(hit)
    );

    frame_ram #(.depth(img_width * img_height)) ram (
        .clk_25mhz(clk_25mhz), .reset_SD_card(reset_SD_card),
        .addr_a(addr_a), .wdata_a(wdata_a), .we_a(we_a), .addr_b(raster_addr),
        .rdata_a(buf_rdata), .rdata_b(pixel)
    );

    palette_lut palette (.index(pixel), .red(red_out), .green(green_out), .blue(blue_out));

    sd_image_store #(.img_pixels(img_width * img_height)) store (
        .clk_25mhz(clk_25mhz), .reset_SD_card(reset_SD_card),
        .draw(draw), .slide_show_en(slide_show_en), .next_image(next_image),
        .buf_rdata(buf_rdata), .sd_ready(sd_ready), .sd_dout(sd_dout),
        .sd_byte_available(sd_byte_available),
        .sd_ready_for_next_byte(sd_ready_for_next_byte),
        .drawing(drawing), .busy(busy), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
        .buf_we(buf_we), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_addr(sd_addr), .sd_din(sd_din)
    );

endmodule

/* testbench/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model import frame_buffer_pkg::*; #(
    parameter int          mem_bytes = 8192,
    parameter logic [31:0] seed_init = 32'h33801270
) (
    input  logic     clk_25mhz,
    input  logic     reset_SD_card,
    input  logic     rd,
    input  logic     wr,
    input  sd_addr_t addr,
    input  sd_byte_t din,
    output logic     ready,
    output sd_byte_t dout,
    output logic     byte_available,
    output logic     ready_for_next_byte
);
    sd_byte_t    mem [mem_bytes];  // card contents, preloaded by the testbench
    logic [31:0] seed = seed_init;
    int          mode;             // 0 waiting, 1 reading a sector, 2 writing a sector
    int          count;
    int          delay;
    int          base;
    logic        hold;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function int byte_delay();     // 1 to 4 cycles per byte
        seed = lcg_step(seed);
        return 1 + int'(seed[17:16]);
    endfunction

    always @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            ready               <= 1'b1;
            byte_available      <= 1'b0;
            ready_for_next_byte <= 1'b0;
            dout                <= '0;
            mode                <= 0;
            hold                <= 1'b0;
        end else begin
            case (mode)
                0: begin
                    if (rd || wr) begin
                        ready <= 1'b0;
                        base  <= int'(addr);
                        count <= 0;
                        delay <= byte_delay();
                        mode  <= rd ? 1 : 2;
                    end
                end
                1: begin
                    if (byte_available) begin
                        byte_available <= 1'b0;  // low at least one cycle between bytes
                        if (count == sector_size) begin
                            ready <= 1'b1;
                            mode  <= 0;
                        end
                    end else if (delay > 1) begin
                        delay <= delay - 1;
                    end else begin
                        dout           <= mem[base + count];
                        byte_available <= 1'b1;
                        count          <= count + 1;
                        delay          <= byte_delay();
                    end
                end
                default: begin
                    if (!ready_for_next_byte) begin
                        if (delay > 1) begin
                            delay <= delay - 1;
                        end else begin
                            ready_for_next_byte <= 1'b1;
                            hold                <= 1'b0;
                        end
                    end else if (!hold) begin
                        hold <= 1'b1;  // store puts the byte on din this cycle
                    end else begin
                        mem[base + count]   <= din;
                        ready_for_next_byte <= 1'b0;
                        count               <= count + 1;
                        delay               <= byte_delay();
                        if (count == sector_size - 1) begin
                            ready <= 1'b1;
                            mode  <= 0;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* testbench/frame_buffer_assert.sv */
`timescale 1ns/1ps

module frame_buffer_assert (
    input logic clk_25mhz,
    input logic reset_SD_card,
    input logic sd_rd,
    input logic sd_wr,
    input logic sd_ready
);
    int fail_count = 0;  // read by the testbench for its verdict

    rd_wr_exclusive: assert property (@(posedge clk_25mhz) disable iff (reset_SD_card)
        !(sd_rd && sd_wr)) else begin
        $error("sd_rd and sd_wr high together");
        fail_count++;
    end

    strobe_when_ready: assert property (@(posedge clk_25mhz) disable iff (reset_SD_card)
        (sd_rd || sd_wr) |-> sd_ready) else begin
        $error("strobe issued while card not ready");
        fail_count++;
    end

    rd_single_cycle: assert property (@(posedge clk_25mhz) disable iff (reset_SD_card)
        sd_rd |=> !sd_rd) else begin
        $error("sd_rd held longer than one cycle");
        fail_count++;
    end

    wr_single_cycle: assert property (@(posedge clk_25mhz) disable iff (reset_SD_card)
        sd_wr |=> !sd_wr) else begin
        $error("sd_wr held longer than one cycle");
        fail_count++;
    end

endmodule

bind sd_image_store frame_buffer_assert strobe_checks (
    .clk_25mhz(clk_25mhz), .reset_SD_card(reset_SD_card),
    .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_ready(sd_ready)
);

/* testbench/tb_frame_buffer.sv */
`timescale 1ns/1ps

module tb_frame_buffer import frame_buffer_pkg::*; ();
    localparam int w        = 32;
    localparam int n        = 1024;
    localparam int n_pre    = 3;                     // images preloaded on the card
    localparam int dir_next = 512 + n_pre * n;       // directory value before the save
    localparam int sectors  = 13;                    // 2 dir reads, 3 save, 8 loads
    localparam int wd_cycles = sectors * 512 * 6 + 12 * 1100 + 2000;

    logic clk_25mhz = 1'b0;
    logic reset_SD_card;
    logic [4:0] hcount, vcount, x_in, y_in;
    logic [2:0] brush_size;
    pixel_t color_in;
    logic draw, slide_show_en, next_image;
    logic sd_ready, sd_byte_available, sd_ready_for_next_byte, sd_rd, sd_wr, busy;
    sd_byte_t sd_dout, sd_din;
    sd_addr_t sd_addr;
    colour_t red_out, green_out, blue_out;

    pixel_t frame [n];          // model of the pixel RAM
    pixel_t images [4][n];      // images expected in the slide show
    pixel_t expect_px [n];
    logic [23:0] palette [16];
    logic [31:0] seed = 32'h33801270;
    int test_errs = 0, tests_run = 0, tests_failed = 0, rd_strobes = 0;
    int assert_fails_seen = 0;  // bound assertion failures already charged to a test
    logic seen_strobe = 1'b0, first_is_rd;
    sd_addr_t first_addr;

    always #20 clk_25mhz = ~clk_25mhz;

    frame_buffer_top #(.img_width(32), .img_height(32)) UUT (.*);

    sd_card_model card (
        .clk_25mhz(clk_25mhz), .reset_SD_card(reset_SD_card), .rd(sd_rd), .wr(sd_wr),
        .addr(sd_addr), .din(sd_din), .ready(sd_ready), .dout(sd_dout),
        .byte_available(sd_byte_available), .ready_for_next_byte(sd_ready_for_next_byte)
    );

    always @(negedge clk_25mhz) begin
        if (!reset_SD_card) begin
            if (sd_rd) rd_strobes++;
            if ((sd_rd || sd_wr) && !seen_strobe) begin
                seen_strobe = 1'b1;
                first_is_rd = sd_rd;
                first_addr  = sd_addr;
            end
        end
    end

    initial begin
        #(wd_cycles * 40);
        $display("watchdog expired, the DUT stopped making progress");
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [7:0] rand_byte();
        seed = lcg_step(seed);
        return seed[23:16];
    endfunction

    function automatic logic brush_covers(input int hx, vy, x, y, size);
        int r, dx, dy;
        r  = 2 * (size + 1) - 1;
        dx = hx - x;
        dy = vy - y;
        return dx * dx + dy * dy <= r * r;
    endfunction

    task scan_compare();
        logic [23:0] got, want;
        for (int a = 0; a <= n; a++) begin
            @(posedge clk_25mhz);
            if (a < n) begin
                hcount <= 5'(a % w);
                vcount <= 5'(a / w);
            end
            @(negedge clk_25mhz);
            if (a > 0) begin
                got  = {red_out, green_out, blue_out};
                want = palette[expect_px[a-1]];
                assert (got == want) else begin
                    $display("** Error at %0t: pixel %0d shows %h, expected %h",
                             $time, a - 1, got, want);
                    test_errs++;
                end
            end
        end
    endtask

    task paint_stroke();
        logic [7:0] r;
        int x, y, size;
        pixel_t c;
        r = rand_byte();
        x = int'(r[4:0]);
        r = rand_byte();
        y = int'(r[4:0]);
        r = rand_byte();
        size = int'(r[2:0]);
        c = r[7:4];
        for (int a = 0; a <= n; a++) begin
            @(posedge clk_25mhz);
            if (a == 0) begin
                x_in       <= 5'(x);
                y_in       <= 5'(y);
                brush_size <= 3'(size);
                color_in   <= c;
            end
            if (a < n) begin
                hcount <= 5'(a % w);
                vcount <= 5'(a / w);
                if (brush_covers(a % w, a / w, x, y, size)) frame[a] = c;
            end
        end
    endtask

    task wait_busy_cycle(input string what);
        int t;
        t = 0;
        while (!busy && t < 50) begin
            @(negedge clk_25mhz);
            t++;
        end
        assert (busy) else begin
            $display("%s never started, busy stayed low", what);
            test_errs++;
        end
        while (busy) @(negedge clk_25mhz);
    endtask

    task pulse_next();
        @(posedge clk_25mhz);
        next_image <= 1'b1;
        @(posedge clk_25mhz);
        next_image <= 1'b0;
    endtask

    task finish_test(input string name);
        test_errs += UUT.store.strobe_checks.fail_count - assert_fails_seen;
        assert_fails_seen = UUT.store.strobe_checks.fail_count;
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (test_errs == 0) ? "ok" : "FAILED", test_errs);
        test_errs = 0;
    endtask

    initial begin
        logic [7:0] rnd;
        int new_next;
        palette = '{24'h000000, 24'hFFFFFF, 24'hFF0000, 24'h00FF00, 24'h0000FF, 24'h00FFFF,
                    24'hFF00FF, 24'hFFFF00, 24'h808080, 24'h6C3082, 24'hFF0080, 24'hFF8000,
                    24'h8000FF, 24'h0080FF, 24'h00FF80, 24'h80FF00};
        reset_SD_card <= 1'b1;
        {hcount, vcount, x_in, y_in} <= '0;
        brush_size <= '0;
        color_in <= '0;
        {draw, slide_show_en, next_image} <= '0;
        for (int i = 0; i < 8192; i++) card.mem[i] = 8'(i) ^ 8'(i >> 8);  // blank card noise
        for (int i = 0; i < 512; i++) card.mem[i] = '0;
        for (int b = 0; b < 4; b++) card.mem[b] = 8'(dir_next >> (8 * b));
        for (int k = 0; k < n_pre; k++) begin
            for (int i = 0; i < n; i++) begin
                rnd = rand_byte();
                images[k][i] = (k == 0 && i < 16) ? 4'(i) : rnd[3:0];  // all 16 colours
                card.mem[512 + k * n + i] = {4'h0, images[k][i]};
            end
        end
        for (int i = 0; i < n; i++) frame[i] = '0;
        repeat (4) @(posedge clk_25mhz);
        reset_SD_card <= 1'b0;

        while (busy || reset_SD_card) @(negedge clk_25mhz);
        assert (seen_strobe && first_is_rd && first_addr == 0) else begin
            $display("** Error at %0t: first strobe was not sd_rd of sector 0", $time);
            test_errs++;
        end
        expect_px = frame;
        scan_compare();
        finish_test("reset and directory read");

        @(posedge clk_25mhz);
        draw <= 1'b1;
        repeat (3) @(posedge clk_25mhz);
        repeat (3) paint_stroke();
        @(posedge clk_25mhz);
        draw <= 1'b0;
        wait_busy_cycle("save");
        expect_px = frame;
        scan_compare();
        finish_test("drawing");

        new_next = dir_next + n;
        for (int i = 0; i < n; i++) begin
            assert (card.mem[dir_next + i] == {4'h0, frame[i]}) else begin
                $display("** Error at %0t: card byte %0d is %h, expected %h", $time,
                         dir_next + i, card.mem[dir_next + i], frame[i]);
                test_errs++;
            end
        end
        for (int b = 0; b < 512; b++) begin
            assert (card.mem[b] == ((b < 4) ? 8'(new_next >> (8 * b)) : 8'h00)) else begin
                $display("** Error at %0t: directory byte %0d is %h", $time, b, card.mem[b]);
                test_errs++;
            end
        end
        finish_test("save");

        images[3] = frame;
        @(posedge clk_25mhz);
        slide_show_en <= 1'b1;
        wait_busy_cycle("directory reload");
        for (int k = 0; k < 4; k++) begin
            pulse_next();
            wait_busy_cycle("image load");
            expect_px = images[k];
            scan_compare();
        end
        finish_test("slide show");

        rnd = 8'(rd_strobes);
        pulse_next();
        repeat (20) @(negedge clk_25mhz);
        assert (8'(rd_strobes) == rnd && !busy) else begin
            $display("** Error at %0t: card read after the last image", $time);
            test_errs++;
        end
        expect_px = images[3];
        scan_compare();
        finish_test("end of images");

        $display("%0d tests, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/frame_buffer_pkg.sv
src/brush_hit.sv
src/frame_ram.sv
src/palette_lut.sv
src/sd_image_store.sv
src/frame_buffer_top.sv
testbench/sd_card_model.sv
testbench/frame_buffer_assert.sv
testbench/tb_frame_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the frame buffer testbench with Verilator.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_frame_buffer \
    -f vlog.f --Mdir obj_dir -o sim_frame_buffer
if [ $? -ne 0 ]; then
    echo "compilation failed"
    exit 1
fi

./obj_dir/sim_frame_buffer > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulator exited with an error status"
fi

if grep -q "^Test completed successfully$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
